// ==== Bender.yml ====
package:
  name: alu_mul

sources:
  - hw/alu_mul_pkg.sv
  - hw/alu_mul_op_decode.sv
  - hw/alu_mul_booth_r4_32.sv
  - hw/alu_mul_csa42.sv
  - hw/alu_mul_reduce.sv
  - hw/alu_mul_top.sv
  - target: test
    files:
      - dv/tb_alu_mul_top.sv

// ==== alu_mul_top.f ====
hw/alu_mul_pkg.sv
hw/alu_mul_op_decode.sv
hw/alu_mul_booth_r4_32.sv
hw/alu_mul_csa42.sv
hw/alu_mul_reduce.sv
hw/alu_mul_top.sv
dv/tb_alu_mul_top.sv

// ==== dv/alu_mul_stimulus.txt ====
# op rs1 rs2 expected, one operation per line, driven back to back
# op is MUL_LO, MUL_HSS, MUL_HSU or MUL_HUU; rs1, rs2 and expected are hex
MUL_LO  00000003 00000007 00000015
MUL_LO  FFFFFFFD 00000007 FFFFFFEB
MUL_LO  FFFFFFFF FFFFFFFF 00000001
MUL_LO  00012345 00010000 23450000
MUL_LO  FFFFFFFE 00000005 FFFFFFF6
MUL_LO  7FFFFFFF 7FFFFFFF 00000001
MUL_HSS 80000000 80000000 40000000
MUL_HSS 80000000 FFFFFFFF 00000000
MUL_HSS 7FFFFFFF 7FFFFFFF 3FFFFFFF
MUL_HSS 80000000 7FFFFFFF C0000000
MUL_HSS FFFFFFFF FFFFFFFF 00000000
MUL_HSU FFFFFFFF 80000000 FFFFFFFF
MUL_HSS FFFFFFFF 80000000 00000000
MUL_HUU FFFFFFFF 80000000 7FFFFFFF
MUL_HSU 80000000 FFFFFFFF 80000000
MUL_HUU FFFFFFFF FFFFFFFF FFFFFFFE
MUL_HUU 80000000 80000000 40000000
MUL_HSU 00000002 FFFFFFFF 00000001
MUL_LO  DEADBEEF 00000010 EADBEEF0
MUL_HUU 00010000 00010000 00000001
MUL_HSS FFFFFFFE 00000003 FFFFFFFF
MUL_HSU FFFFFFFE 00000003 FFFFFFFF

// ==== dv/tb_alu_mul_top.sv ====
`timescale 1ns/100ps

module tb_alu_mul_top;

  logic                    clk_i;
  logic                    rst_n_i;
  logic                    valid_i;
  alu_mul_pkg::mul_funct_t mul_funct_i;
  alu_mul_pkg::xlen_t      rs1_i;
  alu_mul_pkg::xlen_t      rs2_i;
  logic                    valid_o;
  alu_mul_pkg::xlen_t      result_o;

  alu_mul_pkg::xlen_t exp_q [$];
  int                 issue_q [$];
  int                 cycle_cnt = 0;
  int                 check_cnt = 0;
  int                 fail_cnt = 0;
  int                 other_cnt = 0;
  int                 result_idx = 0;
  int                 fd;
  int                 n;
  int                 wait_cnt;
  string              line;
  string              op_name;
  logic [2:0]         funct_code;
  alu_mul_pkg::xlen_t a_val;
  alu_mul_pkg::xlen_t b_val;
  alu_mul_pkg::xlen_t e_val;
  alu_mul_pkg::xlen_t got_exp;
  int                 got_issue;

  alu_mul_top alu_mul_top_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (valid_i),
    .mul_funct_i (mul_funct_i),
    .rs1_i       (rs1_i),
    .rs2_i       (rs2_i),
    .valid_o     (valid_o),
    .result_o    (result_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      $display("[FAIL] %0t: %s got %h, expected %h", $time, what, got, exp);
      fail_cnt++;
    end
  endtask

  function automatic logic [2:0] parse_funct(input string name);
    // Bit 2 flags an unknown name
    case (name)
      "MUL_LO":  return {1'b0, alu_mul_pkg::MUL_LO};
      "MUL_HSS": return {1'b0, alu_mul_pkg::MUL_HSS};
      "MUL_HSU": return {1'b0, alu_mul_pkg::MUL_HSU};
      "MUL_HUU": return {1'b0, alu_mul_pkg::MUL_HUU};
      default:   return 3'b100;
    endcase
  endfunction

  // Outputs sampled mid-cycle
  always @(negedge clk_i) begin
    if (valid_i === 1'b1 && rst_n_i === 1'b1) issue_q.push_back(cycle_cnt); // Cycle valid_i is presented
    if (valid_o === 1'b1) begin
      if (rst_n_i !== 1'b1) begin
        $display("ERROR %0t: valid_o was high while reset was asserted", $time);
        other_cnt++;
      end else if (exp_q.size() == 0 || issue_q.size() == 0) begin
        $display("ERROR %0t: valid_o was high with no operation outstanding", $time);
        other_cnt++;
      end else begin
        got_exp   = exp_q.pop_front();
        got_issue = issue_q.pop_front();
        check_value($sformatf("result of op %0d", result_idx), result_o, got_exp);
        check_value($sformatf("latency of op %0d", result_idx), cycle_cnt - got_issue, 3);
        result_idx++;
      end
    end else if (valid_o !== 1'b0 && cycle_cnt > 0) begin
      $display("ERROR %0t: valid_o is unknown", $time);
      other_cnt++;
    end
  end

  initial begin
    rst_n_i     = 1'b0;
    valid_i     = 1'b0;
    mul_funct_i = '0;
    rs1_i       = '0;
    rs2_i       = '0;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    repeat (2) @(posedge clk_i);

    fd = $fopen("dv/alu_mul_stimulus.txt", "r");
    if (fd == 0) begin
      $display("ERROR: could not open the stimulus file dv/alu_mul_stimulus.txt");
      other_cnt++;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n == 0) break;
        if (line.len() < 2 || line[0] == "#") continue;
        if ($sscanf(line, "%s %h %h %h", op_name, a_val, b_val, e_val) != 4) begin
          $display("ERROR: stimulus line could not be parsed: %s", line);
          other_cnt++;
          continue;
        end
        funct_code = parse_funct(op_name);
        if (funct_code[2]) begin
          $display("ERROR: unknown operation %s in the stimulus file", op_name);
          other_cnt++;
          continue;
        end
        @(posedge clk_i);
        valid_i     <= 1'b1;
        mul_funct_i <= funct_code[1:0];
        rs1_i       <= a_val;
        rs2_i       <= b_val;
        exp_q.push_back(e_val);
      end
      $fclose(fd);
    end
    @(posedge clk_i);
    valid_i <= 1'b0;

    wait_cnt = 0;
    while (exp_q.size() != 0 && wait_cnt < 20) begin
      @(posedge clk_i);
      wait_cnt++;
    end
    if (exp_q.size() != 0) begin
      $display("ERROR: results stopped arriving, %0d operations still outstanding", exp_q.size());
      other_cnt++;
    end
    repeat (10) @(posedge clk_i); // Watch for stray strobes

    $display("Checks: %0d, value mismatches: %0d, other errors: %0d",
             check_cnt, fail_cnt, other_cnt);
    if (fail_cnt == 0 && other_cnt == 0 && check_cnt > 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== hw/alu_mul_booth_r4_32.sv ====
`timescale 1ns/100ps

module alu_mul_booth_r4_32 (
  input  logic                rs1_signed_valid_i,
  input  logic                rs2_signed_valid_i,
  input  alu_mul_pkg::xlen_t  rs1_data_i,
  input  alu_mul_pkg::xlen_t  rs2_data_i,
  output alu_mul_pkg::dword_t pp0_o,
  output alu_mul_pkg::dword_t pp1_o,
  output alu_mul_pkg::dword_t pp2_o,
  output alu_mul_pkg::dword_t pp3_o,
  output alu_mul_pkg::dword_t pp4_o,
  output alu_mul_pkg::dword_t pp5_o,
  output alu_mul_pkg::dword_t pp6_o,
  output alu_mul_pkg::dword_t pp7_o,
  output alu_mul_pkg::dword_t pp8_o,
  output alu_mul_pkg::dword_t pp9_o,
  output alu_mul_pkg::dword_t pp10_o,
  output alu_mul_pkg::dword_t pp11_o,
  output alu_mul_pkg::dword_t pp12_o,
  output alu_mul_pkg::dword_t pp13_o,
  output alu_mul_pkg::dword_t pp14_o,
  output alu_mul_pkg::dword_t pp15_o,
  output alu_mul_pkg::dword_t pp16_o
);

  logic [33:0] rs1_ext;
  logic [33:0] rs2_ext;
  logic [33:0] x_pos;
  logic [33:0] x_dbl;
  logic [33:0] x_neg;
  logic [33:0] x_neg_dbl;
  logic [34:0] scan;
  alu_mul_pkg::dword_t pp [alu_mul_pkg::PP_NUM];

  // Two extra bits keep unsigned operands positive
  assign rs1_ext = {{2{rs1_signed_valid_i & rs1_data_i[31]}}, rs1_data_i};
  assign rs2_ext = {{2{rs2_signed_valid_i & rs2_data_i[31]}}, rs2_data_i};

  assign x_pos     = rs1_ext;
  assign x_dbl     = {rs1_ext[32:0], 1'b0};
  assign x_neg     = ~rs1_ext + 34'd1;
  assign x_neg_dbl = {x_neg[32:0], 1'b0};

  assign scan = {rs2_ext, 1'b0}; // Implicit zero below the LSB

  for (genvar gi = 0; gi < alu_mul_pkg::PP_NUM; gi++) begin : gen_digit
    logic [2:0]  digit;
    logic [33:0] sel;

    assign digit = scan[2*gi+2 -: 3];

    always_comb begin
      case (digit)
        3'b001, 3'b010: sel = x_pos;
        3'b011:         sel = x_dbl;
        3'b100:         sel = x_neg_dbl;
        3'b101, 3'b110: sel = x_neg;
        default:        sel = '0; // 000 and 111
      endcase
    end

    // Sign-extend to 64 bits, then weight by 4^gi
    assign pp[gi] = {{30{sel[33]}}, sel} << (2 * gi);
  end

  assign pp0_o  = pp[0];
  assign pp1_o  = pp[1];
  assign pp2_o  = pp[2];
  assign pp3_o  = pp[3];
  assign pp4_o  = pp[4];
  assign pp5_o  = pp[5];
  assign pp6_o  = pp[6];
  assign pp7_o  = pp[7];
  assign pp8_o  = pp[8];
  assign pp9_o  = pp[9];
  assign pp10_o = pp[10];
  assign pp11_o = pp[11];
  assign pp12_o = pp[12];
  assign pp13_o = pp[13];
  assign pp14_o = pp[14];
  assign pp15_o = pp[15];
  assign pp16_o = pp[16]; // Only nonzero for an unsigned rs2 with bit 31 set

endmodule

// ==== hw/alu_mul_csa42.sv ====
`timescale 1ns/100ps

module alu_mul_csa42 (
  input  alu_mul_pkg::dword_t in0_i,
  input  alu_mul_pkg::dword_t in1_i,
  input  alu_mul_pkg::dword_t in2_i,
  input  alu_mul_pkg::dword_t in3_i,
  output alu_mul_pkg::dword_t sum_o,
  output alu_mul_pkg::dword_t carry_o
);

  alu_mul_pkg::dword_t row0_sum;
  alu_mul_pkg::dword_t row0_maj;
  alu_mul_pkg::dword_t row0_carry;
  alu_mul_pkg::dword_t row1_maj;

  // First full-adder row on in0..in2
  assign row0_sum   = in0_i ^ in1_i ^ in2_i;
  assign row0_maj   = (in0_i & in1_i) | (in0_i & in2_i) | (in1_i & in2_i);
  assign row0_carry = {row0_maj[62:0], 1'b0};

  // Second row folds in in3
  assign sum_o    = row0_sum ^ row0_carry ^ in3_i;
  assign row1_maj = (row0_sum & row0_carry) | (row0_sum & in3_i) | (row0_carry & in3_i);
  assign carry_o  = {row1_maj[62:0], 1'b0}; // Bit 63 carry dropped, mod 2^64

endmodule

// ==== hw/alu_mul_op_decode.sv ====
`timescale 1ns/100ps

module alu_mul_op_decode (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    valid_i,
  input  alu_mul_pkg::mul_funct_t mul_funct_i,
  input  alu_mul_pkg::xlen_t      rs1_i,
  input  alu_mul_pkg::xlen_t      rs2_i,
  output logic                    valid_o,
  output alu_mul_pkg::xlen_t      rs1_o,
  output alu_mul_pkg::xlen_t      rs2_o,
  output logic                    rs1_signed_o,
  output logic                    rs2_signed_o,
  output logic                    sel_high_o
);

  logic rs1_signed_d;
  logic rs2_signed_d;
  logic sel_high_d;

  assign rs1_signed_d = (mul_funct_i == alu_mul_pkg::MUL_HSS) ||
                        (mul_funct_i == alu_mul_pkg::MUL_HSU);
  assign rs2_signed_d = (mul_funct_i == alu_mul_pkg::MUL_HSS);
  assign sel_high_d   = (mul_funct_i != alu_mul_pkg::MUL_LO);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // Request payload, held between strobes
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      rs1_o        <= rs1_i;
      rs2_o        <= rs2_i;
      rs1_signed_o <= rs1_signed_d;
      rs2_signed_o <= rs2_signed_d;
      sel_high_o   <= sel_high_d;
    end
  end

endmodule

// ==== hw/alu_mul_pkg.sv ====
package alu_mul_pkg;

  // Operand and result word
  typedef logic [31:0] xlen_t;

  // Partial product and carry-save vector
  typedef logic [63:0] dword_t;

  // Multiply operation code
  typedef logic [1:0] mul_funct_t;

  localparam mul_funct_t MUL_LO  = 2'd0; // Low word, sign does not matter
  localparam mul_funct_t MUL_HSS = 2'd1; // High word, signed x signed
  localparam mul_funct_t MUL_HSU = 2'd2; // High word, signed x unsigned
  localparam mul_funct_t MUL_HUU = 2'd3; // High word, unsigned x unsigned

  // Radix-4 Booth digits for a 34-bit multiplier
  localparam int PP_NUM = 17;

endpackage

// ==== hw/alu_mul_reduce.sv ====
`timescale 1ns/100ps

module alu_mul_reduce (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                valid_i,
  input  logic                sel_high_i,
  input  alu_mul_pkg::dword_t sum0_i,
  input  alu_mul_pkg::dword_t sum1_i,
  input  alu_mul_pkg::dword_t sum2_i,
  input  alu_mul_pkg::dword_t sum3_i,
  input  alu_mul_pkg::dword_t carry0_i,
  input  alu_mul_pkg::dword_t carry1_i,
  input  alu_mul_pkg::dword_t carry2_i,
  input  alu_mul_pkg::dword_t carry3_i,
  input  alu_mul_pkg::dword_t pp_last_i,
  output logic                valid_o,
  output alu_mul_pkg::xlen_t  result_o
);

  logic                valid_q;
  logic                sel_high_q;
  alu_mul_pkg::dword_t vec_q [9];
  alu_mul_pkg::dword_t row_sum [7];
  alu_mul_pkg::dword_t row_carry [7];
  alu_mul_pkg::dword_t product;

  // Stage 2
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      sel_high_q <= sel_high_i;
      vec_q[0]   <= sum0_i;
      vec_q[1]   <= carry0_i;
      vec_q[2]   <= sum1_i;
      vec_q[3]   <= carry1_i;
      vec_q[4]   <= sum2_i;
      vec_q[5]   <= carry2_i;
      vec_q[6]   <= sum3_i;
      vec_q[7]   <= carry3_i;
      vec_q[8]   <= pp_last_i;
    end
  end

  // 3:2 chain, each row absorbs one more vector
  for (genvar r = 0; r < 7; r++) begin : gen_row
    alu_mul_pkg::dword_t a;
    alu_mul_pkg::dword_t b;
    alu_mul_pkg::dword_t c;
    alu_mul_pkg::dword_t maj;

    if (r == 0) begin : g_first
      assign a = vec_q[0];
      assign b = vec_q[1];
    end else begin : g_next
      assign a = row_sum[r-1];
      assign b = row_carry[r-1];
    end
    assign c = vec_q[r+2];

    assign row_sum[r]   = a ^ b ^ c;
    assign maj          = (a & b) | (a & c) | (b & c);
    assign row_carry[r] = {maj[62:0], 1'b0};
  end

  assign product = row_sum[6] + row_carry[6]; // Carry-propagate adder

  // Stage 3
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_q) begin
      result_o <= sel_high_q ? product[63:32] : product[31:0];
    end
  end

endmodule

// ==== hw/alu_mul_top.sv ====
`timescale 1ns/100ps

module alu_mul_top (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    valid_i,
  input  alu_mul_pkg::mul_funct_t mul_funct_i,
  input  alu_mul_pkg::xlen_t      rs1_i,
  input  alu_mul_pkg::xlen_t      rs2_i,
  output logic                    valid_o,
  output alu_mul_pkg::xlen_t      result_o
);

  logic                s1_valid;
  logic                s1_rs1_signed;
  logic                s1_rs2_signed;
  logic                s1_sel_high;
  alu_mul_pkg::xlen_t  s1_rs1;
  alu_mul_pkg::xlen_t  s1_rs2;
  alu_mul_pkg::dword_t pp [alu_mul_pkg::PP_NUM];
  alu_mul_pkg::dword_t csa_sum [4];
  alu_mul_pkg::dword_t csa_carry [4];

  alu_mul_op_decode alu_mul_op_decode_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .valid_i      (valid_i),
    .mul_funct_i  (mul_funct_i),
    .rs1_i        (rs1_i),
    .rs2_i        (rs2_i),
    .valid_o      (s1_valid),
    .rs1_o        (s1_rs1),
    .rs2_o        (s1_rs2),
    .rs1_signed_o (s1_rs1_signed),
    .rs2_signed_o (s1_rs2_signed),
    .sel_high_o   (s1_sel_high)
  );

  alu_mul_booth_r4_32 alu_mul_booth_r4_32_i (
    .rs1_signed_valid_i (s1_rs1_signed),
    .rs2_signed_valid_i (s1_rs2_signed),
    .rs1_data_i         (s1_rs1),
    .rs2_data_i         (s1_rs2),
    .pp0_o  (pp[0]),  .pp1_o  (pp[1]),  .pp2_o  (pp[2]),  .pp3_o  (pp[3]),
    .pp4_o  (pp[4]),  .pp5_o  (pp[5]),  .pp6_o  (pp[6]),  .pp7_o  (pp[7]),
    .pp8_o  (pp[8]),  .pp9_o  (pp[9]),  .pp10_o (pp[10]), .pp11_o (pp[11]),
    .pp12_o (pp[12]), .pp13_o (pp[13]), .pp14_o (pp[14]), .pp15_o (pp[15]),
    .pp16_o (pp[16])
  );

  // Groups of four partial products
  for (genvar k = 0; k < 4; k++) begin : gen_csa
    alu_mul_csa42 alu_mul_csa42_i (
      .in0_i   (pp[4*k]),
      .in1_i   (pp[4*k+1]),
      .in2_i   (pp[4*k+2]),
      .in3_i   (pp[4*k+3]),
      .sum_o   (csa_sum[k]),
      .carry_o (csa_carry[k])
    );
  end

  alu_mul_reduce alu_mul_reduce_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .valid_i    (s1_valid),
    .sel_high_i (s1_sel_high),
    .sum0_i     (csa_sum[0]),
    .sum1_i     (csa_sum[1]),
    .sum2_i     (csa_sum[2]),
    .sum3_i     (csa_sum[3]),
    .carry0_i   (csa_carry[0]),
    .carry1_i   (csa_carry[1]),
    .carry2_i   (csa_carry[2]),
    .carry3_i   (csa_carry[3]),
    .pp_last_i  (pp[alu_mul_pkg::PP_NUM-1]), // Left over after the 4:2 stage
    .valid_o    (valid_o),
    .result_o   (result_o)
  );

endmodule
